// File: Bender.yml
package:
  name: axi_mem_subsys

sources:
  - axi_mem_pkg.sv
  - axi_mem_slave.sv
  - burst_writer.sv
  - burst_reader.sv
  - mem_subsys_top.sv
  - target: test
    files:
      - tb_mem_subsys.sv

// File: axi_mem_pkg.sv
// shared widths, AXI4 channel structs, stream types and FSM encodings for the memory subsystem
`default_nettype none

package axi_mem_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam logic [ADDR_WIDTH-1:0] ADDR_MASK = 32'h00ff_ffff;
	localparam int DATA_WIDTH = 64;
	localparam int STRB_WIDTH = 8;
	localparam int LEN_WIDTH = 8;
	localparam int MEM_DEPTH = 1024;

	// byte offset bits within a 64-bit word
	localparam int WORD_LSB = $clog2(STRB_WIDTH);
	localparam int WORD_IDX_WIDTH = ADDR_WIDTH - WORD_LSB;
	localparam int MEM_IDX_WIDTH = $clog2(MEM_DEPTH);

	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2
	} resp_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_DATA,
		RD_RESP
	} rd_state_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len;
	} axi_aw_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len;
	} axi_ar_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
		logic                  last;
	} axi_w_t;

	typedef struct packed {
		resp_t resp;
	} axi_b_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		resp_t                 resp;
		logic                  last;
	} axi_r_t;

	// stream beat, strobe is all ones on the read side
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
	} beat_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len;
	} burst_cmd_t;

endpackage

`default_nettype wire

// File: axi_mem_slave.sv
// AXI4 INCR-burst memory slave with masked addressing, byte strobes and range errors
`timescale 1ns/1ps
`default_nettype none

module axi_mem_slave (
	input  wire                        aclk,
	input  wire                        rst_n,
	input  wire axi_mem_pkg::axi_aw_t  aw,
	input  wire                        awvalid,
	output logic                       awready,
	input  wire axi_mem_pkg::axi_w_t   w,
	input  wire                        wvalid,
	output logic                       wready,
	output axi_mem_pkg::axi_b_t        b,
	output logic                       bvalid,
	input  wire                        bready,
	input  wire axi_mem_pkg::axi_ar_t  ar,
	input  wire                        arvalid,
	output logic                       arready,
	output axi_mem_pkg::axi_r_t        r,
	output logic                       rvalid,
	input  wire                        rready
);
	import axi_mem_pkg::*;

	logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

	wr_state_t                 wr_state;
	logic [ADDR_WIDTH-1:0]     aw_masked;
	logic [WORD_IDX_WIDTH-1:0] wr_idx;
	logic [LEN_WIDTH-1:0]      wr_cnt;
	logic                      wr_err;
	logic                      wr_beat;
	logic                      wr_in_range;

	rd_state_t                 rd_state;
	logic [ADDR_WIDTH-1:0]     ar_masked;
	logic [WORD_IDX_WIDTH-1:0] rd_idx;
	logic [WORD_IDX_WIDTH-1:0] rd_addr;
	logic [LEN_WIDTH-1:0]      rd_cnt;
	logic [DATA_WIDTH-1:0]     rd_data;
	logic                      ar_hs;
	logic                      r_hs;
	logic                      rd_load;

	assign aw_masked = aw.addr & ADDR_MASK;
	assign wr_beat = (wr_state == WR_DATA) && wvalid;
	assign wr_in_range = (wr_idx < MEM_DEPTH);

	// write channel FSM
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
			wr_err <= 1'b0;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (awvalid) begin
						wr_state <= WR_DATA;
						wr_err <= 1'b0;
					end
				end
				WR_DATA: begin
					if (wvalid) begin
						// wlast out of step with the length is also an error
						if (!wr_in_range || (w.last != (wr_cnt == '0))) begin
							wr_err <= 1'b1;
						end
						if (wr_cnt == '0) begin
							wr_state <= WR_RESP;
						end
					end
				end
				WR_RESP: begin
					if (bready) begin
						wr_state <= WR_IDLE;
					end
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_state == WR_IDLE && awvalid) begin
			wr_idx <= aw_masked[ADDR_WIDTH-1:WORD_LSB];
			wr_cnt <= aw.len;
		end else if (wr_beat) begin
			wr_idx <= wr_idx + 1'b1;
			wr_cnt <= wr_cnt - 1'b1;
		end
	end

	// byte lanes, beats past the end are dropped
	always_ff @(posedge aclk) begin
		if (wr_beat && wr_in_range) begin
			for (int i = 0; i < STRB_WIDTH; i++) begin
				if (w.strb[i]) begin
					mem[wr_idx[MEM_IDX_WIDTH-1:0]][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
	end

	assign awready = (wr_state == WR_IDLE);
	assign wready = (wr_state == WR_DATA);
	assign bvalid = (wr_state == WR_RESP);

	always_comb begin
		b.resp = wr_err ? SLVERR : OKAY;
	end

	assign ar_masked = ar.addr & ADDR_MASK;
	assign ar_hs = (rd_state == RD_IDLE) && arvalid;
	assign r_hs = (rd_state == RD_DATA) && rready;
	assign rd_load = ar_hs || (r_hs && rd_cnt != '0);

	// next word to fetch, first beat comes straight from ar
	assign rd_addr = (rd_state == RD_IDLE) ? ar_masked[ADDR_WIDTH-1:WORD_LSB] : rd_idx + 1'b1;

	// read channel FSM
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (arvalid) begin
						rd_state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (rready && rd_cnt == '0) begin
						rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (ar_hs) begin
			rd_cnt <= ar.len;
		end else if (r_hs && rd_cnt != '0) begin
			rd_cnt <= rd_cnt - 1'b1;
		end
		if (rd_load) begin
			rd_idx <= rd_addr;
			rd_data <= (rd_addr < MEM_DEPTH) ? mem[rd_addr[MEM_IDX_WIDTH-1:0]] : '0;
		end
	end

	assign arready = (rd_state == RD_IDLE);
	assign rvalid = (rd_state == RD_DATA);

	always_comb begin
		r.data = rd_data;
		r.resp = (rd_idx < MEM_DEPTH) ? OKAY : SLVERR;
		r.last = (rd_cnt == '0);
	end

endmodule

`default_nettype wire

// File: build.f
axi_mem_pkg.sv
axi_mem_slave.sv
burst_writer.sv
burst_reader.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: burst_reader.sv
// burst reader, fetches one AXI4 read burst and hands the beats out as a stream
`timescale 1ns/1ps
`default_nettype none

module burst_reader (
	input  wire                           aclk,
	input  wire                           rst_n,
	input  wire                           start,
	input  wire axi_mem_pkg::burst_cmd_t  cmd,
	output axi_mem_pkg::axi_ar_t          ar,
	output logic                          arvalid,
	input  wire                           arready,
	input  wire axi_mem_pkg::axi_r_t      r,
	input  wire                           rvalid,
	output logic                          rready,
	output axi_mem_pkg::beat_t            out_beat,
	output logic                          out_valid,
	input  wire                           out_ready,
	output logic                          busy,
	output logic                          done,
	output logic                          err
);
	import axi_mem_pkg::*;

	rd_state_t  state;
	burst_cmd_t cmd_q;
	logic       ar_pend;
	logic       err_acc;
	logic       out_hs;
	logic       beat_err;

	assign out_hs = out_valid && out_ready;
	assign beat_err = (r.resp == SLVERR);

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state <= RD_IDLE;
			ar_pend <= 1'b0;
			err_acc <= 1'b0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (start) begin
						state <= RD_DATA;
						ar_pend <= 1'b1;
						err_acc <= 1'b0;
					end
				end
				RD_DATA: begin
					if (ar_pend && arready) begin
						ar_pend <= 1'b0;
					end
					if (out_hs) begin
						err_acc <= err_acc | beat_err;
						if (r.last) begin
							state <= RD_IDLE;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state == RD_IDLE && start) begin
			cmd_q <= cmd;
		end
	end

	assign busy = (state != RD_IDLE);
	assign arvalid = ar_pend;
	assign ar = '{addr: cmd_q.addr, len: cmd_q.len};

	assign rready = (state == RD_DATA) && out_ready;
	assign out_valid = (state == RD_DATA) && rvalid;
	assign out_beat = '{data: r.data, strb: '1};

	// done on the rlast handshake, err includes this beat
	assign done = out_hs && r.last;
	assign err = err_acc | beat_err;

endmodule

`default_nettype wire

// File: burst_writer.sv
// burst writer, turns a command and an input beat stream into one AXI4 write burst
`timescale 1ns/1ps
`default_nettype none

module burst_writer (
	input  wire                           aclk,
	input  wire                           rst_n,
	input  wire                           start,
	input  wire axi_mem_pkg::burst_cmd_t  cmd,
	input  wire axi_mem_pkg::beat_t       in_beat,
	input  wire                           in_valid,
	output logic                          in_ready,
	output axi_mem_pkg::axi_aw_t          aw,
	output logic                          awvalid,
	input  wire                           awready,
	output axi_mem_pkg::axi_w_t           w,
	output logic                          wvalid,
	input  wire                           wready,
	input  wire axi_mem_pkg::axi_b_t      b,
	input  wire                           bvalid,
	output logic                          bready,
	output logic                          busy,
	output logic                          done,
	output logic                          err
);
	import axi_mem_pkg::*;

	wr_state_t            state;
	burst_cmd_t           cmd_q;
	logic [LEN_WIDTH-1:0] beat_cnt;
	logic                 aw_pend;
	logic                 w_hs;

	assign w_hs = wvalid && wready;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state <= WR_IDLE;
			aw_pend <= 1'b0;
			done <= 1'b0;
			err <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (start) begin
						state <= WR_DATA;
						aw_pend <= 1'b1;
					end
				end
				WR_DATA: begin
					if (aw_pend && awready) begin
						aw_pend <= 1'b0;
					end
					if (w_hs && beat_cnt == '0) begin
						state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (bvalid) begin
						state <= WR_IDLE;
						done <= 1'b1;
						err <= (b.resp == SLVERR);
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// beats left, zero on the last one
	always_ff @(posedge aclk) begin
		if (state == WR_IDLE && start) begin
			cmd_q <= cmd;
			beat_cnt <= cmd.len;
		end else if (w_hs) begin
			beat_cnt <= beat_cnt - 1'b1;
		end
	end

	assign busy = (state != WR_IDLE);
	assign awvalid = aw_pend;
	assign aw = '{addr: cmd_q.addr, len: cmd_q.len};

	// stream passes through, either side can stall
	assign wvalid = (state == WR_DATA) && in_valid;
	assign in_ready = (state == WR_DATA) && wready;
	assign w = '{data: in_beat.data, strb: in_beat.strb, last: (beat_cnt == '0)};

	assign bready = (state == WR_RESP);

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
// memory subsystem top, burst writer and burst reader sharing one AXI4 memory slave
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
	input  wire                           aclk,
	input  wire                           rst_n,
	input  wire                           wr_start,
	input  wire axi_mem_pkg::burst_cmd_t  wr_cmd,
	input  wire axi_mem_pkg::beat_t       in_beat,
	input  wire                           in_valid,
	output wire                           in_ready,
	output wire                           wr_busy,
	output wire                           wr_done,
	output wire                           wr_err,
	input  wire                           rd_start,
	input  wire axi_mem_pkg::burst_cmd_t  rd_cmd,
	output wire axi_mem_pkg::beat_t       out_beat,
	output wire                           out_valid,
	input  wire                           out_ready,
	output wire                           rd_busy,
	output wire                           rd_done,
	output wire                           rd_err
);
	import axi_mem_pkg::*;

	wire axi_aw_t aw;
	wire          awvalid;
	wire          awready;
	wire axi_w_t  w;
	wire          wvalid;
	wire          wready;
	wire axi_b_t  b;
	wire          bvalid;
	wire          bready;
	wire axi_ar_t ar;
	wire          arvalid;
	wire          arready;
	wire axi_r_t  r;
	wire          rvalid;
	wire          rready;

	burst_writer u_writer (
		.aclk     (aclk),
		.rst_n    (rst_n),
		.start    (wr_start),
		.cmd      (wr_cmd),
		.in_beat  (in_beat),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.aw       (aw),
		.awvalid  (awvalid),
		.awready  (awready),
		.w        (w),
		.wvalid   (wvalid),
		.wready   (wready),
		.b        (b),
		.bvalid   (bvalid),
		.bready   (bready),
		.busy     (wr_busy),
		.done     (wr_done),
		.err      (wr_err)
	);

	burst_reader u_reader (
		.aclk      (aclk),
		.rst_n     (rst_n),
		.start     (rd_start),
		.cmd       (rd_cmd),
		.ar        (ar),
		.arvalid   (arvalid),
		.arready   (arready),
		.r         (r),
		.rvalid    (rvalid),
		.rready    (rready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.busy      (rd_busy),
		.done      (rd_done),
		.err       (rd_err)
	);

	axi_mem_slave u_slave (
		.aclk    (aclk),
		.rst_n   (rst_n),
		.aw      (aw),
		.awvalid (awvalid),
		.awready (awready),
		.w       (w),
		.wvalid  (wvalid),
		.wready  (wready),
		.b       (b),
		.bvalid  (bvalid),
		.bready  (bready),
		.ar      (ar),
		.arvalid (arvalid),
		.arready (arready),
		.r       (r),
		.rvalid  (rvalid),
		.rready  (rready)
	);

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
// testbench for the memory subsystem, random bursts checked against a word-array model
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
	import axi_mem_pkg::*;

	localparam int MAX_BEATS = 32;
	localparam int NUM_BURSTS = 8;
	localparam int ERR_BURSTS = 4;
	localparam int PAIRS = 4;
	// fill, three write/read phases, range errors, concurrent pairs with a read-back
	localparam int TOTAL_BEATS = MEM_DEPTH + 3 * NUM_BURSTS * MAX_BEATS * 2
		+ ERR_BURSTS * MAX_BEATS * 2 + PAIRS * MAX_BEATS * 3;
	localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 40 + 1000;

	logic       aclk;
	logic       rst_n;
	logic       wr_start;
	burst_cmd_t wr_cmd;
	beat_t      in_beat;
	logic       in_valid;
	logic       in_ready;
	logic       wr_busy;
	logic       wr_done;
	logic       wr_err;
	logic       rd_start;
	burst_cmd_t rd_cmd;
	beat_t      out_beat;
	logic       out_valid;
	logic       out_ready;
	logic       rd_busy;
	logic       rd_done;
	logic       rd_err;

	integer seed = 32'h4364;
	int checks = 0;
	int errors = 0;
	logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];

	mem_subsys_top u_dut (
		.aclk      (aclk),
		.rst_n     (rst_n),
		.wr_start  (wr_start),
		.wr_cmd    (wr_cmd),
		.in_beat   (in_beat),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.wr_busy   (wr_busy),
		.wr_done   (wr_done),
		.wr_err    (wr_err),
		.rd_start  (rd_start),
		.rd_cmd    (rd_cmd),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.rd_busy   (rd_busy),
		.rd_done   (rd_done),
		.rd_err    (rd_err)
	);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// random upper bits above the 24-bit mask alias away
	function automatic logic [31:0] make_addr(input int idx);
		logic [7:0] upper;
		upper = $random(seed);
		return {upper, 24'(idx * 8)};
	endfunction

	function automatic logic [63:0] fill_word(input int idx);
		logic [31:0] v;
		v = idx;
		return {v ^ 32'h5a0f_c3e1, v * 32'h9e37_79b1};
	endfunction

	task automatic write_burst(input logic [31:0] addr, input int len, input bit fill,
			input bit rand_strb, input bit gaps);
		beat_t beats[$];
		beat_t bt;
		int base;
		int idx;
		int sent;
		int r;
		bit hs;
		bit exp_err;
		base = (addr & ADDR_MASK) >> 3;
		exp_err = (base + len >= MEM_DEPTH);
		for (int i = 0; i <= len; i++) begin
			r = $random(seed);
			if (fill) begin
				bt.data = fill_word(base + i);
			end else begin
				bt.data = {$random(seed), $random(seed)};
			end
			bt.strb = rand_strb ? r[7:0] : 8'hff;
			beats.push_back(bt);
		end
		@(posedge aclk);
		wr_start <= 1'b1;
		wr_cmd <= '{addr: addr, len: len[7:0]};
		@(posedge aclk);
		wr_start <= 1'b0;
		sent = 0;
		while (1) begin
			hs = in_valid && in_ready;
			if (hs) begin
				sent++;
				check_value("wr_busy", wr_busy, 1'b1);
			end
			if (sent > len) begin
				in_valid <= 1'b0;
				break;
			end
			// a held beat stays until it is taken
			if (hs || !in_valid) begin
				if (gaps && rand_below(4) == 0) begin
					in_valid <= 1'b0;
				end else begin
					in_valid <= 1'b1;
					in_beat <= beats[sent];
				end
			end
			@(posedge aclk);
		end
		do begin
			@(posedge aclk);
		end while (!wr_done);
		check_value("wr_err", wr_err, exp_err);
		for (int i = 0; i <= len; i++) begin
			idx = base + i;
			if (idx < MEM_DEPTH) begin
				for (int k = 0; k < 8; k++) begin
					if (beats[i].strb[k]) begin
						model_mem[idx][8*k +: 8] = beats[i].data[8*k +: 8];
					end
				end
			end
		end
	endtask

	task automatic read_burst(input logic [31:0] addr, input int len, input bit stall);
		int base;
		int idx;
		int cnt;
		bit finished;
		bit exp_err;
		logic [63:0] exp_data;
		base = (addr & ADDR_MASK) >> 3;
		exp_err = (base + len >= MEM_DEPTH);
		@(posedge aclk);
		rd_start <= 1'b1;
		rd_cmd <= '{addr: addr, len: len[7:0]};
		out_ready <= 1'b1;
		@(posedge aclk);
		rd_start <= 1'b0;
		cnt = 0;
		finished = 1'b0;
		while (!finished) begin
			if (out_valid && out_ready) begin
				idx = base + cnt;
				// past the end reads back as zero
				if (idx < MEM_DEPTH) begin
					exp_data = model_mem[idx];
				end else begin
					exp_data = '0;
				end
				check_value("out_beat.data", out_beat.data, exp_data);
				check_value("out_beat.strb", out_beat.strb, 8'hff);
				check_value("rd_busy", rd_busy, 1'b1);
				cnt++;
				if (rd_done) begin
					check_value("rd_err", rd_err, exp_err);
					check_value("out beat count", cnt, len + 1);
					finished = 1'b1;
				end
			end
			if (!finished) begin
				out_ready <= stall ? (rand_below(4) != 0) : 1'b1;
				@(posedge aclk);
			end
		end
	endtask

	task automatic run_write_read(input int n, input bit rand_strb, input bit stall);
		int len;
		int idx;
		for (int k = 0; k < n; k++) begin
			len = rand_below(MAX_BEATS);
			idx = rand_below(MEM_DEPTH - len);
			write_burst(make_addr(idx), len, 1'b0, rand_strb, stall);
			read_burst(make_addr(idx), len, stall);
		end
	endtask

	initial begin
		int len;
		int idx;
		int rlen;
		int ridx;
		rst_n <= 1'b0;
		wr_start <= 1'b0;
		wr_cmd <= '0;
		in_beat <= '0;
		in_valid <= 1'b0;
		rd_start <= 1'b0;
		rd_cmd <= '0;
		out_ready <= 1'b0;
		repeat (8) @(posedge aclk);
		rst_n <= 1'b1;
		@(posedge aclk);
		check_value("in_ready", in_ready, 0);
		check_value("out_valid", out_valid, 0);
		check_value("wr_busy", wr_busy, 0);
		check_value("rd_busy", rd_busy, 0);
		check_value("wr_done", wr_done, 0);
		check_value("rd_done", rd_done, 0);

		// whole array gets a known pattern first
		for (int i = 0; i < MEM_DEPTH / 256; i++) begin
			write_burst(make_addr(i * 256), 255, 1'b1, 1'b0, 1'b0);
		end

		run_write_read(NUM_BURSTS, 1'b0, 1'b0);
		run_write_read(NUM_BURSTS, 1'b1, 1'b0);
		run_write_read(NUM_BURSTS, 1'b1, 1'b1);

		// bursts crossing the end of the array
		for (int k = 0; k < ERR_BURSTS; k++) begin
			len = 1 + rand_below(MAX_BEATS - 1);
			idx = MEM_DEPTH - 1 - rand_below(len);
			write_burst(make_addr(idx), len, 1'b0, 1'b1, 1'b1);
			read_burst(make_addr(idx), len, 1'b1);
		end

		// write low half while reading high half
		for (int k = 0; k < PAIRS; k++) begin
			len = rand_below(MAX_BEATS);
			idx = rand_below(MEM_DEPTH / 2 - len);
			rlen = rand_below(MAX_BEATS);
			ridx = MEM_DEPTH / 2 + rand_below(MEM_DEPTH / 2 - rlen);
			fork
				write_burst(make_addr(idx), len, 1'b0, 1'b1, 1'b1);
				read_burst(make_addr(ridx), rlen, 1'b1);
			join
			read_burst(make_addr(idx), len, 1'b0);
		end

		repeat (5) @(posedge aclk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge aclk);
		$display("Error: run timed out after %0d cycles, a burst never completed",
			TIMEOUT_CYCLES);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
